// File: memOrder_config.svh
`ifndef MEMORDER_CONFIG_SVH
`define MEMORDER_CONFIG_SVH

// Number of load buffer entries, kept a power of two
`define LB_SIZE 8

// Width of both the instruction and the load sequence numbers
`define SQN_BITS 6

// Depth of the word-addressed data ROM
`define ROM_WORDS 256

// Every address at or above this base belongs to the memory-mapped I/O region
`define MMIO_BASE 32'hFF00_0000

`endif

// File: memOrderPkg.sv
`include "memOrder_config.svh"

package memOrderPkg;

    // Sequence numbers wrap, so age is always compared by signed difference
    typedef logic [`SQN_BITS-1:0] SqN;

    typedef enum logic {
        LOAD,
        STORE
    } MemOpcode;

    // Phases of the four-phase handshake at the operation port
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        RELEASE
    } HandshakeState;

    // ROM port arbitration between early and late loads
    typedef enum logic {
        FREE,
        LATE_PENDING
    } ArbState;

    // Operation as presented by the requester, size is byte, half or word
    typedef struct packed {
        MemOpcode    opcode;
        logic [31:0] base;
        logic [31:0] offset;
        logic [1:0]  size;
        logic        signExtend;
        SqN          sqN;
        SqN          loadSqN;
        logic [31:0] pc;
    } MemOp;

    typedef struct packed {
        logic        valid;
        MemOpcode    opcode;
        logic [31:0] addr;
        logic [1:0]  size;
        logic        signExtend;
        SqN          sqN;
        SqN          loadSqN;
        logic [31:0] pc;
        logic        isMMIO;
    } AguUop;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [1:0]  size;
        logic        signExtend;
        SqN          sqN;
        SqN          loadSqN;
        logic        isMMIO;
    } LdUop;

    typedef struct packed {
        logic        valid;
        SqN          sqN;
        logic [31:0] data;
    } LdResult;

    // Restart request, sqN and loadSqN are those of the store that caused it
    typedef struct packed {
        logic        taken;
        SqN          sqN;
        SqN          loadSqN;
        logic [31:0] dstPC;
    } Redirect;

endpackage

// File: addrGenUnit.sv
`timescale 1ns/10ps
`include "memOrder_config.svh"

module addrGenUnit import memOrderPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  opReq,
    output logic  opAck,
    input  MemOp  op,
    output AguUop agLoad,
    output AguUop agStore
);

    HandshakeState state;
    MemOp          opReg;
    logic [31:0]   addr;
    AguUop         uop;

    // The handshake FSM accepts in IDLE, emits the micro-op in BUSY and
    // then waits in RELEASE until the requester withdraws its request
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (opReq) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    state <= RELEASE;
                end
                RELEASE: begin
                    if (!opReq) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // The operation is captured once, on the edge that starts the handshake
    always_ff @(posedge clk) begin
        if (state == IDLE && opReq) begin
            opReg <= op;
        end
    end

    // Ack comes up with the micro-op and stays until req has fallen
    assign opAck = (state != IDLE);

    assign addr = opReg.base + opReg.offset;

    always_comb begin
        uop.valid      = (state == BUSY);
        uop.opcode     = opReg.opcode;
        uop.addr       = addr;
        uop.size       = opReg.size;
        uop.signExtend = opReg.signExtend;
        uop.sqN        = opReg.sqN;
        uop.loadSqN    = opReg.loadSqN;
        uop.pc         = opReg.pc;
        uop.isMMIO     = (addr >= `MMIO_BASE);

        // Steer the single micro-op to the port matching its opcode
        agLoad         = uop;
        agLoad.valid   = uop.valid && (opReg.opcode == LOAD);
        agStore        = uop;
        agStore.valid  = uop.valid && (opReg.opcode == STORE);
    end

    // The buffer relies on seeing at most one new operation per cycle
    assert property (@(posedge clk) disable iff (rst)
        !(agLoad.valid && agStore.valid));

endmodule

// File: loadBuffer.sv
`timescale 1ns/10ps
`include "memOrder_config.svh"

module loadBuffer import memOrderPkg::*; #(
    parameter int NUM_ENTRIES = `LB_SIZE
) (
    input  logic    clk,
    input  logic    rst,
    input  SqN      commitSqN,
    input  AguUop   agLoad,
    input  AguUop   agStore,
    input  logic    stall,
    input  Redirect branch,
    output LdUop    earlyLd,
    output LdUop    lateLd,
    output Redirect redirect,
    output SqN      maxLoadSqN
);

    localparam int IDX_BITS = $clog2(NUM_ENTRIES);
    localparam int TAG_BITS = `SQN_BITS - IDX_BITS;

    // The low load sequence bits are the entry index, only the rest is stored
    typedef struct packed {
        SqN                  sqN;
        logic [TAG_BITS-1:0] highLdSqN;
        logic [1:0]          size;
        logic [31:0]         addr;
        logic                signExtend;
        logic                isMMIO;
        logic                issued;
        logic                valid;
    } LbEntry;

    if ((1 << IDX_BITS) != NUM_ENTRIES) begin : gDepthCheck
        $error("loadBuffer NUM_ENTRIES must be a power of two");
    end

    LbEntry              entries [NUM_ENTRIES];
    SqN                  baseIndex;
    logic [IDX_BITS-1:0] deqIndex;
    logic [IDX_BITS-1:0] insIndex;
    logic [IDX_BITS-1:0] retireIdx;
    logic                delayLoad;
    logic                isCollision;
    logic                issueLate;
    logic                loadKept;
    logic                storeKept;
    logic                retireRun;
    logic [3:0]          retireMask;
    logic [2:0]          retireCount;

    // Byte lanes touched by an access of the given size within its word
    function automatic logic [3:0] laneMask(logic [1:0] offs, logic [1:0] size);
        case (size)
            2'd0:    return 4'b0001 << offs;
            2'd1:    return 4'b0011 << {offs[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic overlaps(logic [31:0] ldAddr, logic [1:0] ldSize,
                                      logic [31:0] stAddr, logic [1:0] stSize);
        logic sameWord;
        sameWord = (ldAddr[31:2] == stAddr[31:2]);
        return sameWord && |(laneMask(ldAddr[1:0], ldSize) & laneMask(stAddr[1:0], stSize));
    endfunction

    assign deqIndex = baseIndex[IDX_BITS-1:0];
    assign insIndex = agLoad.loadSqN[IDX_BITS-1:0];

    // Anything flushed by a redirect in this same cycle is not recorded
    assign loadKept  = agLoad.valid &&
                       (!branch.taken || $signed(agLoad.sqN - branch.sqN) <= 0);
    assign storeKept = agStore.valid &&
                       (!branch.taken || $signed(agStore.sqN - branch.sqN) <= 0);

    // Early path. MMIO loads must wait for commit, and a load hit by an older
    // store of the same cycle would read stale data, so both go late
    always_comb begin
        delayLoad = agLoad.isMMIO;
        if (agStore.valid && $signed(agStore.loadSqN - agLoad.loadSqN) <= 0 &&
            overlaps(agLoad.addr, agLoad.size, agStore.addr, agStore.size)) begin
            delayLoad = 1'b1;
        end

        earlyLd.valid      = agLoad.valid && !delayLoad;
        earlyLd.addr       = agLoad.addr;
        earlyLd.size       = agLoad.size;
        earlyLd.signExtend = agLoad.signExtend;
        earlyLd.sqN        = agLoad.sqN;
        earlyLd.loadSqN    = agLoad.loadSqN;
        earlyLd.isMMIO     = agLoad.isMMIO;
    end

    // A store that hits an issued load which is younger than itself means
    // that load read memory too early
    always_comb begin
        isCollision = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entries[i].valid && entries[i].issued &&
                $signed(agStore.loadSqN - {entries[i].highLdSqN, IDX_BITS'(i)}) <= 0 &&
                overlaps(entries[i].addr, entries[i].size, agStore.addr, agStore.size)) begin
                isCollision = 1'b1;
            end
        end
    end

    // Only the head may go late, MMIO ones once they are next to commit
    assign issueLate = !branch.taken && !lateLd.valid &&
                       entries[deqIndex].valid && !entries[deqIndex].issued &&
                       (!entries[deqIndex].isMMIO || commitSqN == entries[deqIndex].sqN);

    // Up to four consecutive committed entries from the head leave per cycle
    always_comb begin
        retireMask  = '0;
        retireCount = '0;
        retireRun   = 1'b1;
        retireIdx   = deqIndex;
        for (int i = 0; i < 4; i++) begin
            retireIdx = deqIndex + IDX_BITS'(i);
            if (retireRun && entries[retireIdx].valid && entries[retireIdx].issued &&
                $signed(commitSqN - entries[retireIdx].sqN) > 0) begin
                retireMask[i] = 1'b1;
                retireCount   = retireCount + 3'd1;
            end else begin
                retireRun = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
            baseIndex      <= '0;
            maxLoadSqN     <= SqN'(NUM_ENTRIES - 1);
            lateLd.valid   <= 1'b0;
            redirect.taken <= 1'b0;
        end else begin
            // The late load is consumed on any cycle the execution unit is not stalling
            if (!stall) begin
                lateLd.valid <= 1'b0;
            end
            redirect.taken <= 1'b0;

            if (branch.taken) begin
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if ($signed(entries[i].sqN - branch.sqN) > 0) begin
                        entries[i].valid <= 1'b0;
                    end
                end
                if ($signed(lateLd.sqN - branch.sqN) > 0) begin
                    lateLd.valid <= 1'b0;
                end
            end else if (issueLate) begin
                lateLd.valid            <= 1'b1;
                lateLd.addr             <= entries[deqIndex].addr;
                lateLd.size             <= entries[deqIndex].size;
                lateLd.signExtend       <= entries[deqIndex].signExtend;
                lateLd.sqN              <= entries[deqIndex].sqN;
                lateLd.loadSqN          <= {entries[deqIndex].highLdSqN, deqIndex};
                lateLd.isMMIO           <= entries[deqIndex].isMMIO;
                entries[deqIndex].issued <= 1'b1;
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (retireMask[i]) begin
                        entries[deqIndex + IDX_BITS'(i)].valid <= 1'b0;
                    end
                end
                baseIndex <= baseIndex + SqN'(retireCount);
            end

            if (loadKept) begin
                entries[insIndex] <= '{
                    sqN:        agLoad.sqN,
                    highLdSqN:  agLoad.loadSqN[`SQN_BITS-1:IDX_BITS],
                    size:       agLoad.size,
                    addr:       agLoad.addr,
                    signExtend: agLoad.signExtend,
                    isMMIO:     agLoad.isMMIO,
                    issued:     !delayLoad,
                    valid:      1'b1
                };
            end

            // Restart right after the store, its fetch state is all we keep
            if (storeKept && isCollision) begin
                redirect.taken   <= 1'b1;
                redirect.sqN     <= agStore.sqN;
                redirect.loadSqN <= agStore.loadSqN;
                redirect.dstPC   <= agStore.pc + 32'd4;
            end

            // Lags the head pointer by one cycle
            maxLoadSqN <= baseIndex + SqN'(NUM_ENTRIES - 1);
        end
    end

    // A freshly issued late load leaves a live entry marked issued behind it
    assert property (@(posedge clk) disable iff (rst)
        $rose(lateLd.valid) |-> entries[lateLd.loadSqN[IDX_BITS-1:0]].valid &&
                                entries[lateLd.loadSqN[IDX_BITS-1:0]].issued);

endmodule

// File: loadExecUnit.sv
`timescale 1ns/10ps
`include "memOrder_config.svh"

module loadExecUnit import memOrderPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  LdUop    earlyLd,
    input  LdUop    lateLd,
    output logic    stall,
    output LdResult result
);

    localparam int WORD_BITS = $clog2(`ROM_WORDS);

    logic [31:0] rom [`ROM_WORDS];
    ArbState     state;
    LdUop        sel;
    logic [31:0] rawWord;
    logic [31:0] shifted;
    logic [31:0] formatted;

    // Fixed contents, so each word can be predicted from its index
    initial begin
        for (int w = 0; w < `ROM_WORDS; w++) begin
            rom[w] = w * 32'h0101_0101 + 32'h00F0_8000;
        end
    end

    // Early loads own the port. A colliding late load is held by the buffer
    // through stall and gets the port on the following cycle
    always_comb begin
        stall = (state == FREE) && earlyLd.valid && lateLd.valid;
        if (state == LATE_PENDING || !earlyLd.valid) begin
            sel = lateLd;
        end else begin
            sel = earlyLd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FREE;
        end else begin
            case (state)
                FREE: begin
                    if (stall) begin
                        state <= LATE_PENDING;
                    end
                end
                default: begin
                    state <= FREE;
                end
            endcase
        end
    end

    // MMIO reads return the low address half twice instead of ROM data
    assign rawWord = sel.isMMIO ? {sel.addr[15:0], sel.addr[15:0]} :
                                  rom[sel.addr[WORD_BITS+1:2]];
    assign shifted = rawWord >> {sel.addr[1:0], 3'b000};

    always_comb begin
        case (sel.size)
            2'd0:    formatted = {{24{sel.signExtend & shifted[7]}}, shifted[7:0]};
            2'd1:    formatted = {{16{sel.signExtend & shifted[15]}}, shifted[15:0]};
            default: formatted = rawWord;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= sel.valid;
        end
        result.sqN  <= sel.sqN;
        result.data <= formatted;
    end

    // The handshake spaces early loads, so none lands in the cycle
    // reserved for a waiting late load
    assert property (@(posedge clk) disable iff (rst)
        state == LATE_PENDING |-> !earlyLd.valid);

    // The buffer must keep the stalled late load on its output
    assert property (@(posedge clk) disable iff (rst)
        stall |=> lateLd.valid);

endmodule

// File: memOrderUnit.sv
`timescale 1ns/10ps

module memOrderUnit import memOrderPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    opReq,
    output logic    opAck,
    input  MemOp    op,
    input  SqN      commitSqN,
    output LdResult result,
    output Redirect redirect,
    output SqN      maxLoadSqN
);

    AguUop agLoad;
    AguUop agStore;
    LdUop  earlyLd;
    LdUop  lateLd;
    logic  stall;

    addrGenUnit u_addrGenUnit (
        .clk     (clk),
        .rst     (rst),
        .opReq   (opReq),
        .opAck   (opAck),
        .op      (op),
        .agLoad  (agLoad),
        .agStore (agStore)
    );

    // The buffer's own redirect returns as its branch input to flush younger loads
    loadBuffer u_loadBuffer (
        .clk        (clk),
        .rst        (rst),
        .commitSqN  (commitSqN),
        .agLoad     (agLoad),
        .agStore    (agStore),
        .stall      (stall),
        .branch     (redirect),
        .earlyLd    (earlyLd),
        .lateLd     (lateLd),
        .redirect   (redirect),
        .maxLoadSqN (maxLoadSqN)
    );

    loadExecUnit u_loadExecUnit (
        .clk     (clk),
        .rst     (rst),
        .earlyLd (earlyLd),
        .lateLd  (lateLd),
        .stall   (stall),
        .result  (result)
    );

endmodule

// File: tbMemOrderUnit.sv
`timescale 1ns/10ps
`include "memOrder_config.svh"

module tbMemOrderUnit import memOrderPkg::*; ();

    logic    clk;
    logic    rst;
    logic    opReq;
    logic    opAck;
    MemOp    op;
    SqN      commitSqN;
    LdResult result;
    Redirect redirect;
    SqN      maxLoadSqN;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycleLimit = 1000;
    logic        prevAck = 1'b0;
    SqN          resSqN [$];
    logic [31:0] resData [$];
    SqN          redSqN [$];
    SqN          redLdSqN [$];
    logic [31:0] redPC [$];

    memOrderUnit u_memOrderUnit (
        .clk        (clk),
        .rst        (rst),
        .opReq      (opReq),
        .opAck      (opAck),
        .op         (op),
        .commitSqN  (commitSqN),
        .result     (result),
        .redirect   (redirect),
        .maxLoadSqN (maxLoadSqN)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
    end

    // The limit follows the number of vectors once the file has been read
    initial begin
        wait (cycles > cycleLimit);
        $display("Run stopped: no progress within %0d cycles", cycleLimit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Outputs settle right after the edge, so sample them 1 ns later
    always begin
        @(posedge clk);
        #1;
        if (!rst) begin
            if (opAck && !prevAck && !opReq) begin
                $display("Handshake broken: opAck rose while opReq was low");
                errors++;
            end
            if (!opAck && prevAck && opReq) begin
                $display("Handshake broken: opAck fell while opReq was still high");
                errors++;
            end
            if (result.valid) begin
                resSqN.push_back(result.sqN);
                resData.push_back(result.data);
            end
            if (redirect.taken) begin
                redSqN.push_back(redirect.sqN);
                redLdSqN.push_back(redirect.loadSqN);
                redPC.push_back(redirect.dstPC);
            end
        end
        prevAck = opAck;
    end

    // Load data as the ROM and MMIO rules define it
    function automatic logic [31:0] expectData(logic [31:0] addr, logic [1:0] size,
                                               logic sign);
        logic [31:0] word;
        logic [31:0] w;
        if (addr >= `MMIO_BASE) begin
            word = {addr[15:0], addr[15:0]};
        end else begin
            w    = 32'(addr[31:2] % `ROM_WORDS);
            word = w * 32'h0101_0101 + 32'h00F0_8000;
        end
        word = word >> (8 * addr[1:0]);
        if (size == 2'd0) begin
            return {{24{sign & word[7]}}, word[7:0]};
        end else if (size == 2'd1) begin
            return {{16{sign & word[15]}}, word[15:0]};
        end
        return word;
    endfunction

    task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic runOp(MemOpcode code, SqN sqN, SqN ldSqN, logic [31:0] addr,
                         logic [1:0] size, logic sign, logic [31:0] pc);
        int n;
        @(negedge clk);
        op.opcode     = code;
        op.base       = addr & 32'hFFFF_FFF0;
        op.offset     = addr & 32'h0000_000F;
        op.size       = size;
        op.signExtend = sign;
        op.sqN        = sqN;
        op.loadSqN    = ldSqN;
        op.pc         = pc;
        opReq         = 1'b1;
        n = 0;
        while (!opAck && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!opAck) begin
            $display("Handshake broken: opAck never rose");
            errors++;
        end
        opReq = 1'b0;
        n = 0;
        while (opAck && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (opAck) begin
            $display("Handshake broken: opAck stayed high after opReq fell");
            errors++;
        end
        repeat ($urandom_range(0, 3)) @(negedge clk);
    endtask

    task automatic waitResult(string name, SqN expSqN, logic [31:0] expData);
        int n;
        n = 0;
        while (resData.size() == 0 && n < 30) begin
            @(negedge clk);
            n++;
        end
        if (resData.size() == 0) begin
            $display("Test %s: no load result arrived", name);
            errors++;
        end else begin
            checkValue(name, expData, resData.pop_front());
            checkValue(name, 32'(expSqN), 32'(resSqN.pop_front()));
        end
    endtask

    task automatic expectQuiet(string name);
        repeat (10) @(negedge clk);
        if (resData.size() != 0) begin
            $display("Test %s: a load result appeared that should not exist", name);
            errors++;
        end
    endtask

    initial begin
        int          fd;
        string       line;
        string       cmd;
        string       name;
        string       lines [$];
        logic [31:0] f [7];
        logic [31:0] heldAddr;
        logic [1:0]  heldSize;
        logic        heldSign;
        rst       = 1'b1;
        opReq     = 1'b0;
        op        = '0;
        commitSqN = '0;
        heldAddr  = '0;
        heldSize  = '0;
        heldSign  = 1'b0;
        void'($urandom(32'h60ac));
        fd = $fopen("memOrderInput.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file memOrderInput.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycleLimit = 40 * lines.size() + 20;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("resetMaxLoadSqN", 32'(`LB_SIZE - 1), 32'(maxLoadSqN));

        foreach (lines[i]) begin
            f = '{default: '0};
            void'($sscanf(lines[i], "%s %s %h %h %h %h %h %h %h", cmd, name,
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6]));
            resSqN.delete();
            resData.delete();
            redSqN.delete();
            redLdSqN.delete();
            redPC.delete();
            if (cmd == "ld") begin
                if (f[5] !== expectData(f[2], f[3][1:0], f[4][0])) begin
                    $display("Test %s: data file value disagrees with the ROM rule", name);
                    errors++;
                end
                runOp(LOAD, SqN'(f[0]), SqN'(f[1]), f[2], f[3][1:0], f[4][0], '0);
                waitResult(name, SqN'(f[0]), f[5]);
            end else if (cmd == "ldq") begin
                heldAddr = f[2];
                heldSize = f[3][1:0];
                heldSign = f[4][0];
                runOp(LOAD, SqN'(f[0]), SqN'(f[1]), f[2], f[3][1:0], f[4][0], '0);
                expectQuiet(name);
            end else if (cmd == "st") begin
                runOp(STORE, SqN'(f[0]), SqN'(f[1]), f[2], f[3][1:0], 1'b0, f[4]);
                repeat (4) @(negedge clk);
                checkValue(name, f[5], 32'(redSqN.size()));
                if (redSqN.size() != 0 && f[5] != 0) begin
                    checkValue(name, f[0], 32'(redSqN.pop_front()));
                    checkValue(name, f[1], 32'(redLdSqN.pop_front()));
                    checkValue(name, f[6], redPC.pop_front());
                end
            end else if (cmd == "cmr") begin
                if (f[1] !== expectData(heldAddr, heldSize, heldSign)) begin
                    $display("Test %s: data file value disagrees with the MMIO rule", name);
                    errors++;
                end
                @(negedge clk);
                commitSqN = SqN'(f[0]);
                waitResult(name, SqN'(f[2]), f[1]);
            end else if (cmd == "cmq") begin
                @(negedge clk);
                commitSqN = SqN'(f[0]);
                expectQuiet(name);
            end else if (cmd == "cmm") begin
                @(negedge clk);
                commitSqN = SqN'(f[0]);
                repeat (6) @(negedge clk);
                checkValue(name, f[1], 32'(maxLoadSqN));
            end else begin
                $display("Unknown command %s in the stimulus file", cmd);
                errors++;
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: memOrderUnit.f
+incdir+.
memOrderPkg.sv
addrGenUnit.sv
loadBuffer.sv
loadExecUnit.sv
memOrderUnit.sv
tbMemOrderUnit.sv

// File: memOrderInput.txt
# cmd name, then hex fields that depend on cmd
# ld  name sqN loadSqN addr size sign expData  | ldq name sqN loadSqN addr size sign
# st  name sqN loadSqN addr size pc expTaken expDstPC
# cmr name commitSqN expData expSqN | cmq name commitSqN | cmm name commitSqN expMaxLoadSqN
ld  byteSigned       01 00 00000011 0 1 ffffff84
ld  halfUnsigned     02 01 00000012 1 0 000004f4
ld  halfSigned       03 02 00000010 1 1 ffff8404
ld  wordLoad         04 03 00000010 2 0 04f48404
cmm retireFour       05 0b
ldq mmioHeld         06 04 ff001234 2 0
cmr mmioRelease      06 12341234 06
ld  byteUnsigned     08 05 00000041 0 0 00000090
st  storeMiss        07 05 00000044 2 00000200 0 00000000
st  storeHit         07 05 00000040 1 00000200 1 00000204
ld  reloadWord       0b 05 00000080 2 0 2110a020
ldq mmioYounger      0c 06 ff000010 2 0
st  storeFlush       0a 05 00000080 2 00000300 1 00000304
cmq flushedMmio      0c
cmm retireAfterFlush 0c 0c
